//--- Bender.yml
package:
  name: mips_lite

sources:
  - verilog/mips_lite_pkg.sv
  - verilog/register_file.sv
  - verilog/fetch_unit.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/writeback_stage.sv
  - verilog/mips_lite_core.sv
  - target: simulation
    files:
      - bench/mips_lite_chk.sv
      - bench/mips_lite_tb.sv

//--- bench/mips_lite_chk.sv
`timescale 1ns/1ps

// mips_lite protocol checker
// watches the four-phase fetch handshake and the retire outputs of the core

module mips_lite_chk (
    input logic                 SYS_clk,
    input logic                 SYS_reset,
    input logic                 fetch_req,
    input logic                 fetch_ack,
    input mips_lite_pkg::word_t fetch_pc,
    input logic                 commit_valid,
    input logic                 exc_valid
);

    int assert_errors = 0;   // read by the testbench

    req_held_until_ack: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        fetch_req && !fetch_ack |=> fetch_req)
    else
    begin
        $error("fetch_req dropped before fetch_ack was seen");
        assert_errors++;
    end

    pc_stable_during_req: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        fetch_req |=> !fetch_req || $stable(fetch_pc))
    else
    begin
        $error("fetch_pc changed while fetch_req was high");
        assert_errors++;
    end

    no_req_while_ack: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !fetch_req && fetch_ack |=> !fetch_req)
    else
    begin
        $error("fetch_req rose while fetch_ack was still high");
        assert_errors++;
    end

    one_retire_per_cycle: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(commit_valid && exc_valid))
    else
    begin
        $error("commit_valid and exc_valid in the same cycle");
        assert_errors++;
    end

endmodule

bind mips_lite_core mips_lite_chk i_chk (
    .SYS_clk      (SYS_clk),
    .SYS_reset    (SYS_reset),
    .fetch_req    (fetch_req),
    .fetch_ack    (fetch_ack),
    .fetch_pc     (fetch_pc),
    .commit_valid (commit_valid),
    .exc_valid    (exc_valid)
);

//--- bench/mips_lite_tb.sv
`timescale 1ns/1ps

// mips_lite testbench
// random program from an LCG, a fetch responder with random ack delays,
// a sequential ISA model and an in-order check of every commit and exception

module mips_lite_tb;
    import mips_lite_pkg::*;

    localparam int   CLK_PERIOD       = 10;
    localparam int   RESET_CYCLES     = 16;
    localparam int   PROG_LEN         = 64;
    localparam int   CYCLES_PER_INSTR = 20;
    localparam int   WATCHDOG_NS      = (RESET_CYCLES + PROG_LEN * CYCLES_PER_INSTR) * CLK_PERIOD;
    localparam word_t LCG_SEED        = 32'd90;

    logic      SYS_clk;
    logic      SYS_reset;
    logic      fetch_ack;
    word_t     fetch_instr;
    logic      fetch_req;
    word_t     fetch_pc;
    logic      commit_valid;
    reg_addr_t commit_reg;
    word_t     commit_data;
    logic      exc_valid;
    exc_code_e exc_code;
    word_t     epc;

    word_t     lcg_state;
    int        fill_idx;
    word_t     program_mem [PROG_LEN];
    string     prog_test   [PROG_LEN];   // behavior each word belongs to
    logic      exp_is_exc  [PROG_LEN];
    reg_addr_t exp_reg     [PROG_LEN];
    word_t     exp_data    [PROG_LEN];
    exc_code_e exp_code    [PROG_LEN];
    word_t     exp_pc      [PROG_LEN];

    mips_lite_core i_dut (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .fetch_ack    (fetch_ack),
        .fetch_instr  (fetch_instr),
        .fetch_req    (fetch_req),
        .fetch_pc     (fetch_pc),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_data  (commit_data),
        .exc_valid    (exc_valid),
        .exc_code     (exc_code),
        .epc          (epc)
    );

    always
    begin
        #(CLK_PERIOD / 2) SYS_clk = ~SYS_clk;
    end

    task automatic next_cycle();
        @(posedge SYS_clk);
        #1;   // drive and sample point
    endtask

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned random_below(int unsigned n);
        return (lcg_next() >> 8) % n;   // low bits of an LCG are weak
    endfunction

    function automatic word_t encode_rtype(logic [5:0] funct, reg_addr_t rs, reg_addr_t rt,
                                           reg_addr_t rd);
        return {6'h00, rs, rt, rd, 5'h00, funct};
    endfunction

    function automatic word_t encode_itype(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] alu_funct(int unsigned k);
        case (k)
            0:       return F_ADD;
            1:       return F_SUB;
            2:       return F_AND;
            3:       return F_OR;
            4:       return F_XOR;
            default: return F_SLT;
        endcase
    endfunction

    function automatic word_t instr_at(word_t pc);
        word_t index;
        index = (pc - RESET_PC) >> 2;
        if (index < PROG_LEN)
            return program_mem[index];
        else
            return encode_rtype(F_OR, 5'd1, 5'd0, 5'd1);   // or $1,$1,$0
    endfunction

    task automatic add_word(word_t w, string test);
        program_mem[fill_idx] = w;
        prog_test[fill_idx]   = test;
        fill_idx++;
    endtask

    task automatic build_program();
        int unsigned pick;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   dst;
        fill_idx = 0;
        add_word(encode_itype(OP_ADDI, 5'd0, 5'd3, 16'd5), "hazard");
        add_word(encode_rtype(F_ADD, 5'd3, 5'd3, 5'd4), "hazard");
        add_word(encode_itype(OP_ADDI, 5'd0, 5'd1, 16'h7FFF), "overflow");
        repeat (17)
            add_word(encode_rtype(F_ADD, 5'd1, 5'd1, 5'd1), "overflow");   // last one wraps
        add_word(encode_rtype(F_OR, 5'd1, 5'd0, 5'd5), "overflow");
        add_word(encode_rtype(6'h21, 5'd3, 5'd4, 5'd6), "illegal");       // addu not supported
        add_word(encode_itype(6'h23, 5'd3, 5'd6, 16'h0010), "illegal");    // lw not supported
        add_word(encode_rtype(F_ADD, 5'd3, 5'd4, 5'd0), "zero_write");
        add_word(encode_rtype(F_ADD, 5'd4, 5'd3, 5'd6), "zero_write");
        while (fill_idx < PROG_LEN)
        begin
            pick = random_below(16);
            rs   = reg_addr_t'(random_below(8));
            rt   = reg_addr_t'(random_below(8));
            dst  = (random_below(16) == 0) ? 5'd0 : reg_addr_t'(1 + random_below(7));
            if (pick == 0)
                add_word(encode_rtype(6'h27, rs, rt, dst), "random_illegal");
            else if (pick < 5)
                add_word(encode_itype(OP_ADDI, rs, dst, 16'(random_below(65536))), "random_addi");
            else
                add_word(encode_rtype(alu_funct(random_below(6)), rs, rt, dst), "random_alu");
        end
    endtask

    // sequential execution, one expected event per program word
    task automatic run_model();
        word_t       regs [32];
        word_t       instr;
        word_t       a;
        word_t       b;
        word_t       res;
        logic [32:0] sum_w;
        logic [32:0] diff_w;
        logic [5:0]  op;
        logic [5:0]  key;
        logic        legal;
        logic        ovf;
        reg_addr_t   dst;
        for (int r = 0; r < 32; r++)
            regs[r] = '0;
        for (int i = 0; i < PROG_LEN; i++)
        begin
            instr  = program_mem[i];
            op     = instr[31:26];
            a      = regs[instr[25:21]];
            b      = (op == OP_ADDI) ? {{16{instr[15]}}, instr[15:0]} : regs[instr[20:16]];
            dst    = (op == OP_ADDI) ? instr[20:16] : instr[15:11];
            key    = (op == OP_ADDI) ? F_ADD : instr[5:0];
            legal  = (op == OP_ADDI) || (op == OP_RTYPE);
            sum_w  = {a[31], a} + {b[31], b};
            diff_w = {a[31], a} - {b[31], b};
            res    = '0;
            case (key)
                F_ADD:   res = sum_w[31:0];
                F_SUB:   res = diff_w[31:0];
                F_AND:   res = a & b;
                F_OR:    res = a | b;
                F_XOR:   res = a ^ b;
                F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: legal = 1'b0;
            endcase
            ovf = (key == F_ADD && sum_w[32] != sum_w[31]) ||
                  (key == F_SUB && diff_w[32] != diff_w[31]);   // 33-bit signed result
            exp_pc[i]     = RESET_PC + word_t'(4 * i);
            exp_reg[i]    = dst;
            exp_data[i]   = res;
            exp_is_exc[i] = 1'b1;
            if (!legal)
                exp_code[i] = EXC_ILLEGAL;
            else if (ovf)
                exp_code[i] = EXC_OVERFLOW;
            else if (dst == '0)
                exp_code[i] = EXC_ZERO_WRITE;
            else
            begin
                exp_code[i]   = EXC_NONE;
                exp_is_exc[i] = 1'b0;
                regs[dst]     = res;
            end
        end
    endtask

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_kind(string test, logic want_exc, logic got_exc);
        if (want_exc != got_exc)
            abort_run($sformatf("%s retired the wrong kind of event, expected %s but saw %s",
                                test, want_exc ? "an exception" : "a commit",
                                got_exc ? "an exception" : "a commit"));
    endtask

    task automatic check_commit(string test, reg_addr_t want_reg, word_t want_data);
        if (commit_reg !== want_reg || commit_data !== want_data)
            abort_run($sformatf("FAIL %s expected $%0d = 0x%08h actual $%0d = 0x%08h",
                                test, want_reg, want_data, commit_reg, commit_data));
    endtask

    task automatic check_exc(string test, exc_code_e want_code, word_t want_pc);
        if (exc_code !== want_code || epc !== want_pc)
            abort_run($sformatf("FAIL %s expected code %0d at 0x%08h actual code %0d at 0x%08h",
                                test, want_code, want_pc, exc_code, epc));
    endtask

    // fetch responder, four-phase order with 0 to 5 cycles per phase
    initial
    begin
        int unsigned wait_cycles;
        forever
        begin
            next_cycle();
            if (fetch_req)
            begin
                wait_cycles = random_below(6);
                repeat (wait_cycles) next_cycle();
                fetch_instr = instr_at(fetch_pc);
                fetch_ack   = 1'b1;
                while (fetch_req)
                    next_cycle();
                wait_cycles = random_below(6);
                repeat (wait_cycles) next_cycle();
                fetch_ack = 1'b0;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        abort_run("timeout, the pipeline stalled before all program events retired");
    end

    initial
    begin
        int checked;
        SYS_clk     = 1'b0;
        SYS_reset   = 1'b1;
        fetch_ack   = 1'b0;
        fetch_instr = '0;
        lcg_state   = LCG_SEED;
        checked     = 0;
        build_program();
        run_model();
        repeat (RESET_CYCLES) @(posedge SYS_clk);
        #1;
        SYS_reset = 1'b0;
        while (checked < PROG_LEN)
        begin
            next_cycle();
            if (i_dut.i_chk.assert_errors != 0)
                abort_run("a fetch handshake or retire output assertion failed");
            if (commit_valid || exc_valid)
            begin
                check_kind(prog_test[checked], exp_is_exc[checked], exc_valid);
                if (exc_valid)
                    check_exc(prog_test[checked], exp_code[checked], exp_pc[checked]);
                else
                    check_commit(prog_test[checked], exp_reg[checked], exp_data[checked]);
                checked++;
            end
        end
        if (i_dut.i_chk.assert_errors == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
            abort_run("a fetch handshake or retire output assertion failed");
    end

endmodule

//--- mips_lite.f
verilog/mips_lite_pkg.sv
verilog/register_file.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/mips_lite_core.sv
bench/mips_lite_chk.sv
bench/mips_lite_tb.sv

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

// mips_lite decode stage
// holds the instruction register, decodes opcode and funct into an ALU op,
// tags illegal words and interlocks on destinations pending in execute or writeback

module decode_stage (
    input  logic                     SYS_clk,
    input  logic                     SYS_reset,
    input  logic                     if_valid,
    input  mips_lite_pkg::word_t     if_instr,
    input  mips_lite_pkg::word_t     if_pc,
    input  logic                     flush,
    input  mips_lite_pkg::reg_addr_t ex_busy_dst,
    input  logic                     ex_busy,
    input  logic                     wb_busy,
    input  logic                     wb_we,
    input  mips_lite_pkg::reg_addr_t wb_addr,
    input  mips_lite_pkg::word_t     wb_data,
    output logic                     id_ready,
    output logic                     id_valid,
    output mips_lite_pkg::alu_op_e   id_alu_op,
    output mips_lite_pkg::word_t     id_rs_val,
    output mips_lite_pkg::word_t     id_opb,
    output mips_lite_pkg::reg_addr_t id_dst,
    output logic                     id_we,
    output mips_lite_pkg::exc_code_e id_exc,
    output mips_lite_pkg::word_t     id_pc
);
    import mips_lite_pkg::*;

    logic      d_valid;
    word_t     d_instr;
    word_t     d_pc;
    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     rs_data;
    word_t     rt_data;
    word_t     imm_sext;
    alu_op_e   alu_op;
    logic      illegal;
    logic      use_imm;
    logic      rs_hit;
    logic      rt_hit;
    logic      stall;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            d_valid <= 1'b0;
        else if (flush)
            d_valid <= 1'b0;
        else if (id_ready)
            d_valid <= if_valid;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (id_ready && if_valid)
        begin
            d_instr <= if_instr;
            d_pc    <= if_pc;
        end
    end

    assign opcode   = opcode_e'(d_instr[31:26]);
    assign funct    = funct_e'(d_instr[5:0]);
    assign rs       = d_instr[25:21];
    assign rt       = d_instr[20:16];
    assign rd       = d_instr[15:11];
    assign imm_sext = {{16{d_instr[15]}}, d_instr[15:0]};

    always_comb
    begin
        alu_op  = ALU_ADD;
        illegal = 1'b0;
        use_imm = 1'b0;
        if (opcode == OP_ADDI)
            use_imm = 1'b1;
        else if (opcode == OP_RTYPE)
        begin
            case (funct)
                F_ADD:   alu_op = ALU_ADD;
                F_SUB:   alu_op = ALU_SUB;
                F_AND:   alu_op = ALU_AND;
                F_OR:    alu_op = ALU_OR;
                F_XOR:   alu_op = ALU_XOR;
                F_SLT:   alu_op = ALU_SLT;
                default: illegal = 1'b1;
            endcase
        end
        else
            illegal = 1'b1;
    end

    // no forwarding, so wait until the producer has left writeback
    assign rs_hit = (rs != '0) &&
                    ((ex_busy && rs == ex_busy_dst) || (wb_busy && rs == wb_addr));
    assign rt_hit = (rt != '0) &&
                    ((ex_busy && rt == ex_busy_dst) || (wb_busy && rt == wb_addr));
    assign stall  = d_valid && !illegal && (rs_hit || (!use_imm && rt_hit));

    register_file u_regs (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (rs),
        .rt_addr   (rt),
        .wb_addr   (wb_addr),
        .wb_we     (wb_we),
        .wb_data   (wb_data),
        .rs_data   (rs_data),
        .rt_data   (rt_data)
    );

    assign id_ready  = !stall;
    assign id_valid  = d_valid && !stall;
    assign id_alu_op = alu_op;
    assign id_rs_val = rs_data;
    assign id_opb    = use_imm ? imm_sext : rt_data;
    assign id_dst    = use_imm ? rt : rd;
    assign id_we     = !illegal;                             // illegal words write nothing
    assign id_exc    = illegal ? EXC_ILLEGAL : EXC_NONE;
    assign id_pc     = d_pc;

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ps

// mips_lite execute stage
// registers the issued operands, runs the ALU and flags signed overflow
// on add, addi and sub

module execute_stage (
    input  logic                     SYS_clk,
    input  logic                     SYS_reset,
    input  logic                     flush,
    input  logic                     id_valid,
    input  mips_lite_pkg::alu_op_e   id_alu_op,
    input  mips_lite_pkg::word_t     id_rs_val,
    input  mips_lite_pkg::word_t     id_opb,
    input  mips_lite_pkg::reg_addr_t id_dst,
    input  logic                     id_we,
    input  mips_lite_pkg::exc_code_e id_exc,
    input  mips_lite_pkg::word_t     id_pc,
    output logic                     ex_valid,
    output mips_lite_pkg::word_t     ex_result,
    output mips_lite_pkg::reg_addr_t ex_dst,
    output logic                     ex_we,
    output mips_lite_pkg::exc_code_e ex_exc,
    output mips_lite_pkg::word_t     ex_pc,
    output logic                     ex_busy,
    output mips_lite_pkg::reg_addr_t ex_busy_dst
);
    import mips_lite_pkg::*;

    logic      x_valid;
    alu_op_e   x_alu_op;
    word_t     x_a;
    word_t     x_b;
    reg_addr_t x_dst;
    logic      x_we;
    exc_code_e x_exc;
    word_t     x_pc;
    word_t     result;
    logic      ovf;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            x_valid <= 1'b0;
        else
            x_valid <= id_valid && !flush;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (id_valid)
        begin
            x_alu_op <= id_alu_op;
            x_a      <= id_rs_val;
            x_b      <= id_opb;
            x_dst    <= id_dst;
            x_we     <= id_we;
            x_exc    <= id_exc;
            x_pc     <= id_pc;
        end
    end

    always_comb
    begin
        result = '0;
        ovf    = 1'b0;
        case (x_alu_op)
            ALU_ADD:
            begin
                result = x_a + x_b;                        // wraps modulo 2^32
                ovf    = (x_a[XLEN-1] == x_b[XLEN-1]) && (result[XLEN-1] != x_a[XLEN-1]);
            end
            ALU_SUB:
            begin
                result = x_a - x_b;
                ovf    = (x_a[XLEN-1] != x_b[XLEN-1]) && (result[XLEN-1] != x_a[XLEN-1]);
            end
            ALU_AND: result = x_a & x_b;
            ALU_OR:  result = x_a | x_b;
            ALU_XOR: result = x_a ^ x_b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(x_a) < $signed(x_b)};
            default: result = '0;
        endcase
    end

    // an older code from decode wins over overflow
    always_comb
    begin
        if (x_exc != EXC_NONE)
            ex_exc = x_exc;
        else if (ovf)
            ex_exc = EXC_OVERFLOW;
        else
            ex_exc = EXC_NONE;
    end

    assign ex_valid    = x_valid;
    assign ex_result   = result;
    assign ex_dst      = x_dst;
    assign ex_we       = x_we && (ex_exc == EXC_NONE);
    assign ex_pc       = x_pc;
    assign ex_busy     = x_valid && ex_we;     // write still pending for decode
    assign ex_busy_dst = x_dst;

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps

// mips_lite fetch unit
// runs the four-phase req/ack handshake toward the instruction source,
// buffers one fetched word for decode and keeps the fetch PC

module fetch_unit (
    input  logic                 SYS_clk,
    input  logic                 SYS_reset,
    input  logic                 fetch_ack,
    input  mips_lite_pkg::word_t fetch_instr,
    input  logic                 id_ready,
    input  logic                 flush,
    input  mips_lite_pkg::word_t flush_pc,
    output logic                 fetch_req,
    output mips_lite_pkg::word_t fetch_pc,
    output logic                 if_valid,
    output mips_lite_pkg::word_t if_instr,
    output mips_lite_pkg::word_t if_pc
);
    import mips_lite_pkg::*;

    fetch_state_e state;
    word_t        next_pc;      // address of the next request
    word_t        held_instr;
    logic         held_valid;
    logic         discard;      // word in flight predates a flush
    logic         capture;
    logic         handover;
    logic         launch;       // a new request starts at this edge
    word_t        launch_pc;

    assign capture   = (state == F_REQ) && fetch_ack;
    assign handover  = held_valid && id_ready;
    assign launch    = !fetch_ack && (!held_valid || handover) && !flush;
    assign launch_pc = handover ? fetch_pc + 32'd4 : next_pc;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            state      <= F_IDLE;
            held_valid <= 1'b0;
            discard    <= 1'b0;
            next_pc    <= RESET_PC;
            fetch_pc   <= RESET_PC;
        end
        else
        begin
            case (state)
                F_IDLE:
                begin
                    if (launch)
                    begin
                        state    <= F_REQ;
                        fetch_pc <= launch_pc;   // frozen for the whole request
                    end
                end
                F_REQ:
                begin
                    if (fetch_ack)
                        state <= F_RELEASE;
                end
                F_RELEASE:
                begin
                    if (launch)
                    begin
                        state    <= F_REQ;       // ack seen low, next request at once
                        fetch_pc <= launch_pc;
                    end
                    else if (!fetch_ack)
                        state <= F_IDLE;
                end
                default:
                    state <= F_IDLE;
            endcase

            if (flush)
                held_valid <= 1'b0;
            else if (capture)
                held_valid <= !discard;
            else if (handover)
                held_valid <= 1'b0;

            if (capture)
                discard <= 1'b0;
            else if (flush && state == F_REQ)
                discard <= 1'b1;

            if (flush)
                next_pc <= flush_pc;           // resume after the faulting word
            else if (handover)
                next_pc <= fetch_pc + 32'd4;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (capture)
            held_instr <= fetch_instr;
    end

    assign fetch_req = (state == F_REQ);
    assign if_valid  = held_valid;
    assign if_instr  = held_instr;
    assign if_pc     = fetch_pc;      // still the address of the held word

endmodule

//--- verilog/mips_lite_core.sv
`timescale 1ns/1ps

// mips_lite core top level
// fetch, decode, execute and writeback stages with the external fetch port,
// the commit stream and the exception report

module mips_lite_core (
    input  logic                     SYS_clk,
    input  logic                     SYS_reset,
    input  logic                     fetch_ack,
    input  mips_lite_pkg::word_t     fetch_instr,
    output logic                     fetch_req,
    output mips_lite_pkg::word_t     fetch_pc,
    output logic                     commit_valid,
    output mips_lite_pkg::reg_addr_t commit_reg,
    output mips_lite_pkg::word_t     commit_data,
    output logic                     exc_valid,
    output mips_lite_pkg::exc_code_e exc_code,
    output mips_lite_pkg::word_t     epc
);
    import mips_lite_pkg::*;

    logic      if_valid;
    word_t     if_instr;
    word_t     if_pc;
    logic      id_ready;
    logic      id_valid;
    alu_op_e   id_alu_op;
    word_t     id_rs_val;
    word_t     id_opb;
    reg_addr_t id_dst;
    logic      id_we;
    exc_code_e id_exc;
    word_t     id_pc;
    logic      ex_valid;
    word_t     ex_result;
    reg_addr_t ex_dst;
    logic      ex_we;
    exc_code_e ex_exc;
    word_t     ex_pc;
    logic      ex_busy;
    reg_addr_t ex_busy_dst;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      wb_busy;
    logic      flush;
    word_t     flush_pc;

    fetch_unit u_fetch (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .fetch_ack   (fetch_ack),
        .fetch_instr (fetch_instr),
        .id_ready    (id_ready),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .if_valid    (if_valid),
        .if_instr    (if_instr),
        .if_pc       (if_pc)
    );

    decode_stage u_decode (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .if_valid    (if_valid),
        .if_instr    (if_instr),
        .if_pc       (if_pc),
        .flush       (flush),
        .ex_busy_dst (ex_busy_dst),
        .ex_busy     (ex_busy),
        .wb_busy     (wb_busy),
        .wb_we       (wb_we),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .id_ready    (id_ready),
        .id_valid    (id_valid),
        .id_alu_op   (id_alu_op),
        .id_rs_val   (id_rs_val),
        .id_opb      (id_opb),
        .id_dst      (id_dst),
        .id_we       (id_we),
        .id_exc      (id_exc),
        .id_pc       (id_pc)
    );

    execute_stage u_execute (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .flush       (flush),
        .id_valid    (id_valid),
        .id_alu_op   (id_alu_op),
        .id_rs_val   (id_rs_val),
        .id_opb      (id_opb),
        .id_dst      (id_dst),
        .id_we       (id_we),
        .id_exc      (id_exc),
        .id_pc       (id_pc),
        .ex_valid    (ex_valid),
        .ex_result   (ex_result),
        .ex_dst      (ex_dst),
        .ex_we       (ex_we),
        .ex_exc      (ex_exc),
        .ex_pc       (ex_pc),
        .ex_busy     (ex_busy),
        .ex_busy_dst (ex_busy_dst)
    );

    writeback_stage u_writeback (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .ex_valid     (ex_valid),
        .ex_result    (ex_result),
        .ex_dst       (ex_dst),
        .ex_we        (ex_we),
        .ex_exc       (ex_exc),
        .ex_pc        (ex_pc),
        .wb_we        (wb_we),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .wb_busy      (wb_busy),
        .flush        (flush),
        .flush_pc     (flush_pc),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_data  (commit_data),
        .exc_valid    (exc_valid),
        .exc_code     (exc_code),
        .epc          (epc)
    );

endmodule

//--- verilog/mips_lite_pkg.sv
// mips_lite shared definitions
// widths, reset vector and the enums for instruction fields,
// ALU operations, exception codes and the fetch handshake state

package mips_lite_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC = 32'h0040_0000;   // first fetch address

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08
    } opcode_e;

    typedef enum logic [5:0] {
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_XOR = 6'h26,
        F_SLT = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [2:0] {
        EXC_NONE       = 3'd0,
        EXC_ILLEGAL    = 3'd1,   // raised in decode
        EXC_OVERFLOW   = 3'd2,   // raised in execute
        EXC_ZERO_WRITE = 3'd7    // raised in writeback
    } exc_code_e;

    typedef enum logic [1:0] {
        F_IDLE,
        F_REQ,
        F_RELEASE
    } fetch_state_e;

endpackage

//--- verilog/register_file.sv
`timescale 1ns/1ps

// mips_lite register file
// 32 entries, two combinational read ports, one write port,
// register zero always reads as zero

module register_file (
    input  logic                     SYS_clk,
    input  logic                     SYS_reset,
    input  mips_lite_pkg::reg_addr_t rs_addr,
    input  mips_lite_pkg::reg_addr_t rt_addr,
    input  mips_lite_pkg::reg_addr_t wb_addr,
    input  logic                     wb_we,
    input  mips_lite_pkg::word_t     wb_data,
    output mips_lite_pkg::word_t     rs_data,
    output mips_lite_pkg::word_t     rt_data
);
    import mips_lite_pkg::*;

    word_t regs [1:31];   // no storage behind register zero

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb_we && wb_addr != '0)
            regs[wb_addr] <= wb_data;
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

//--- verilog/writeback_stage.sv
`timescale 1ns/1ps

// mips_lite writeback stage
// retires one instruction per cycle, either as a register write with a
// commit pulse or as an exception pulse that flushes the younger work

module writeback_stage (
    input  logic                     SYS_clk,
    input  logic                     SYS_reset,
    input  logic                     ex_valid,
    input  mips_lite_pkg::word_t     ex_result,
    input  mips_lite_pkg::reg_addr_t ex_dst,
    input  logic                     ex_we,
    input  mips_lite_pkg::exc_code_e ex_exc,
    input  mips_lite_pkg::word_t     ex_pc,
    output logic                     wb_we,
    output mips_lite_pkg::reg_addr_t wb_addr,
    output mips_lite_pkg::word_t     wb_data,
    output logic                     wb_busy,
    output logic                     flush,
    output mips_lite_pkg::word_t     flush_pc,
    output logic                     commit_valid,
    output mips_lite_pkg::reg_addr_t commit_reg,
    output mips_lite_pkg::word_t     commit_data,
    output logic                     exc_valid,
    output mips_lite_pkg::exc_code_e exc_code,
    output mips_lite_pkg::word_t     epc
);
    import mips_lite_pkg::*;

    logic      w_valid;
    word_t     w_result;
    reg_addr_t w_dst;
    logic      w_we;
    exc_code_e w_exc;
    word_t     w_pc;
    exc_code_e code;
    logic      fault;

    // the word in execute during a fault cycle is younger and is dropped
    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            w_valid <= 1'b0;
        else
            w_valid <= ex_valid && !flush;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (ex_valid)
        begin
            w_result <= ex_result;
            w_dst    <= ex_dst;
            w_we     <= ex_we;
            w_exc    <= ex_exc;
            w_pc     <= ex_pc;
        end
    end

    always_comb
    begin
        if (w_exc != EXC_NONE)
            code = w_exc;
        else if (w_we && w_dst == '0)
            code = EXC_ZERO_WRITE;
        else
            code = EXC_NONE;
    end

    assign fault = w_valid && (code != EXC_NONE);

    assign wb_we        = w_valid && w_we && (code == EXC_NONE);
    assign wb_addr      = w_dst;
    assign wb_data      = w_result;
    assign wb_busy      = w_valid && w_we;
    assign commit_valid = wb_we;
    assign commit_reg   = w_dst;
    assign commit_data  = w_result;
    assign exc_valid    = fault;
    assign exc_code     = code;
    assign epc          = w_pc;
    assign flush        = fault;
    assign flush_pc     = w_pc + 32'd4;   // refetch right after the faulting word

endmodule
